// File: hw/boothStage.sv
`default_nettype none
`include "multDiv_consts.svh"

module boothStage
	import multDivPkg::*;
(
	input wire logic clk,
	input wire logic rstN,
	input wire logic [`MD_WIDTH-1:0] multiplicand,
	input wire boothAcc_t accIn,
	input wire logic extraIn,
	output logic [`MD_WIDTH-1:0] multiplicandOut,
	output boothAcc_t accOut,
	output logic extraOut
);

	logic [2:0] boothBits;
	logic [`MD_WIDTH+1:0] multExt;
	logic [`MD_WIDTH+1:0] addend;
	boothAcc_t sumAcc;

	always_comb begin
		// two multiplier bits plus the bit shifted out last step
		boothBits = {accIn.lo[1:0], extraIn};
		multExt = {{2{multiplicand[`MD_WIDTH-1]}}, multiplicand};
		case (boothBits)
			3'b001, 3'b010: addend = multExt;
			3'b011: addend = multExt << 1;
			3'b100: addend = -(multExt << 1);
			3'b101, 3'b110: addend = -multExt;
			// 000 and 111 add nothing
			default: addend = '0;
		endcase
		sumAcc.hi = accIn.hi + addend;
		sumAcc.lo = accIn.lo;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			multiplicandOut <= '0;
			accOut <= '0;
			extraOut <= 1'b0;
		end else begin
			multiplicandOut <= multiplicand;
			// arithmetic shift keeps the partial product sign
			accOut <= boothAcc_t'($signed(sumAcc) >>> `MD_RADIX_BITS);
			extraOut <= accIn.lo[1];
		end
	end

endmodule

`default_nettype wire

// File: hw/divSetup.sv
`default_nettype none
`include "multDiv_consts.svh"

module divSetup
	import multDivPkg::*;
(
	input wire logic [`MD_WIDTH-1:0] operandA,
	input wire logic [`MD_WIDTH-1:0] operandB,
	output logic [`MD_WIDTH-1:0] dividendMag,
	output divMult_t divisorX1,
	output divMult_t divisorX2,
	output divMult_t divisorX3,
	output logic divZero,
	output logic quotNeg
);

	logic [`MD_WIDTH-1:0] divisorMag;

	always_comb begin
		// magnitudes, the minimum integer stays 0x80000000 read unsigned
		dividendMag = operandA[`MD_WIDTH-1] ? -operandA : operandA;
		divisorMag = operandB[`MD_WIDTH-1] ? -operandB : operandB;

		divisorX1 = {2'b00, divisorMag};
		divisorX2 = {1'b0, divisorMag, 1'b0};
		// three times, one adder
		divisorX3 = divisorX1 + divisorX2;

		divZero = (operandB == '0);
		quotNeg = operandA[`MD_WIDTH-1] ^ operandB[`MD_WIDTH-1];
	end

endmodule

`default_nettype wire

// File: hw/divStage.sv
`default_nettype none
`include "multDiv_consts.svh"

module divStage
	import multDivPkg::*;
(
	input wire logic clk,
	input wire logic rstN,
	input wire divMult_t remIn,
	input wire logic [`MD_WIDTH-1:0] dividendIn,
	input wire logic [`MD_WIDTH-1:0] quotIn,
	input wire divMult_t divisorX1,
	input wire divMult_t divisorX2,
	input wire divMult_t divisorX3,
	output divMult_t remOut,
	output logic [`MD_WIDTH-1:0] dividendOut,
	output logic [`MD_WIDTH-1:0] quotOut,
	output divMult_t divisorX1Out,
	output divMult_t divisorX2Out,
	output divMult_t divisorX3Out
);

	divMult_t remShift;
	// one extra bit on top catches the borrow
	logic [`MD_WIDTH+2:0] diff1;
	logic [`MD_WIDTH+2:0] diff2;
	logic [`MD_WIDTH+2:0] diff3;
	divMult_t remNext;
	logic [1:0] digit;

	always_comb begin
		// remainder stays below the divisor, so its top two bits are zero
		remShift = {remIn[`MD_WIDTH-1:0], dividendIn[`MD_WIDTH-1 -: `MD_RADIX_BITS]};

		// all three trials at once
		diff1 = {1'b0, remShift} - {1'b0, divisorX1};
		diff2 = {1'b0, remShift} - {1'b0, divisorX2};
		diff3 = {1'b0, remShift} - {1'b0, divisorX3};

		// largest multiple that still fits wins
		if (!diff3[`MD_WIDTH+2]) begin
			digit = 2'd3;
			remNext = diff3[`MD_WIDTH+1:0];
		end else if (!diff2[`MD_WIDTH+2]) begin
			digit = 2'd2;
			remNext = diff2[`MD_WIDTH+1:0];
		end else if (!diff1[`MD_WIDTH+2]) begin
			digit = 2'd1;
			remNext = diff1[`MD_WIDTH+1:0];
		end else begin
			digit = 2'd0;
			remNext = remShift;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			remOut <= '0;
			dividendOut <= '0;
			quotOut <= '0;
			divisorX1Out <= '0;
			divisorX2Out <= '0;
			divisorX3Out <= '0;
		end else begin
			remOut <= remNext;
			dividendOut <= dividendIn << `MD_RADIX_BITS;
			quotOut <= {quotIn[`MD_WIDTH-3:0], digit};
			divisorX1Out <= divisorX1;
			divisorX2Out <= divisorX2;
			divisorX3Out <= divisorX3;
		end
	end

	// holds only if every earlier stage also left a remainder below the divisor
	remBelowDivisor: assert property (@(posedge clk) disable iff (!rstN)
		(divisorX1 != '0) |-> (remNext < divisorX1));

endmodule

`default_nettype wire

// File: hw/multDiv.sv
`default_nettype none
`include "multDiv_consts.svh"

module multDiv
	import multDivPkg::*;
(
	input wire logic clk,
	input wire logic rstN,
	input wire logic [`MD_WIDTH-1:0] operandA,
	input wire logic [`MD_WIDTH-1:0] operandB,
	input wire logic ctrlMult,
	input wire logic ctrlDiv,
	output logic [`MD_WIDTH-1:0] result,
	output logic exception,
	output logic resultRdy
);

	// index 0 is the combinational setup, index i+1 the output of stage i
	wire logic [`MD_WIDTH-1:0] multChain [`MD_STAGES+1];
	wire boothAcc_t accChain [`MD_STAGES+1];
	wire logic extraChain [`MD_STAGES+1];

	wire divMult_t remChain [`MD_STAGES+1];
	wire logic [`MD_WIDTH-1:0] dividendChain [`MD_STAGES+1];
	wire logic [`MD_WIDTH-1:0] quotChain [`MD_STAGES+1];
	wire divMult_t x1Chain [`MD_STAGES+1];
	wire divMult_t x2Chain [`MD_STAGES+1];
	wire divMult_t x3Chain [`MD_STAGES+1];

	wire logic divZero;
	wire logic quotNeg;
	wire mdOp_t lastOp;
	wire logic lastDivZero;
	wire logic lastQuotNeg;

	// multiplier starts with hi cleared and operandB in lo
	assign multChain[0] = operandA;
	assign accChain[0] = {{(`MD_WIDTH+2){1'b0}}, operandB};
	assign extraChain[0] = 1'b0;

	// divider starts from an empty remainder and quotient
	assign remChain[0] = '0;
	assign quotChain[0] = '0;

	divSetup setup (
		.operandA(operandA),
		.operandB(operandB),
		.dividendMag(dividendChain[0]),
		.divisorX1(x1Chain[0]),
		.divisorX2(x2Chain[0]),
		.divisorX3(x3Chain[0]),
		.divZero(divZero),
		.quotNeg(quotNeg)
	);

	genvar i;
	generate
		for (i = 0; i < `MD_STAGES; i++) begin : stageGen
			boothStage boothInst (
				.clk(clk),
				.rstN(rstN),
				.multiplicand(multChain[i]),
				.accIn(accChain[i]),
				.extraIn(extraChain[i]),
				.multiplicandOut(multChain[i+1]),
				.accOut(accChain[i+1]),
				.extraOut(extraChain[i+1])
			);

			divStage divInst (
				.clk(clk),
				.rstN(rstN),
				.remIn(remChain[i]),
				.dividendIn(dividendChain[i]),
				.quotIn(quotChain[i]),
				.divisorX1(x1Chain[i]),
				.divisorX2(x2Chain[i]),
				.divisorX3(x3Chain[i]),
				.remOut(remChain[i+1]),
				.dividendOut(dividendChain[i+1]),
				.quotOut(quotChain[i+1]),
				.divisorX1Out(x1Chain[i+1]),
				.divisorX2Out(x2Chain[i+1]),
				.divisorX3Out(x3Chain[i+1])
			);
		end
	endgenerate

	pipeControl control (
		.clk(clk),
		.rstN(rstN),
		.ctrlMult(ctrlMult),
		.ctrlDiv(ctrlDiv),
		.divZero(divZero),
		.quotNeg(quotNeg),
		.lastOp(lastOp),
		.lastDivZero(lastDivZero),
		.lastQuotNeg(lastQuotNeg)
	);

	resultStage outStage (
		.clk(clk),
		.rstN(rstN),
		.lastOp(lastOp),
		.lastDivZero(lastDivZero),
		.lastQuotNeg(lastQuotNeg),
		.acc(accChain[`MD_STAGES]),
		.quotMag(quotChain[`MD_STAGES]),
		.result(result),
		.exception(exception),
		.resultRdy(resultRdy)
	);

endmodule

`default_nettype wire

// File: hw/multDivPkg.sv
`default_nettype none
`include "multDiv_consts.svh"

package multDivPkg;

	// operation tag carried alongside the data
	typedef enum logic [1:0] {
		opNone = 2'd0,
		opMult = 2'd1,
		opDiv = 2'd2
	} mdOp_t;

	// booth accumulator
	// hi holds the running partial product with two guard bits
	// lo starts as the multiplier and ends as the low product word
	typedef struct packed {
		logic [`MD_WIDTH+1:0] hi;
		logic [`MD_WIDTH-1:0] lo;
	} boothAcc_t;

	// divisor multiple, room for three times the largest magnitude
	typedef logic [`MD_WIDTH+1:0] divMult_t;

endpackage

`default_nettype wire

// File: hw/multDiv_consts.svh
`ifndef MULTDIV_CONSTS_SVH
`define MULTDIV_CONSTS_SVH

// operand and result width
`define MD_WIDTH 32

// operand bits retired per pipeline stage, radix 4
`define MD_RADIX_BITS 2

// iterative stages, the same for multiply and divide
`define MD_STAGES (`MD_WIDTH / `MD_RADIX_BITS)

// request to result, stage chain plus the output register
`define MD_LATENCY (`MD_STAGES + 1)

`endif

// File: hw/pipeControl.sv
`default_nettype none
`include "multDiv_consts.svh"

module pipeControl
	import multDivPkg::*;
(
	input wire logic clk,
	input wire logic rstN,
	input wire logic ctrlMult,
	input wire logic ctrlDiv,
	input wire logic divZero,
	input wire logic quotNeg,
	output mdOp_t lastOp,
	output logic lastDivZero,
	output logic lastQuotNeg
);

	// one slot per stage, slot i sits beside the output of stage i
	mdOp_t opTag [`MD_STAGES];
	logic divZeroTag [`MD_STAGES];
	logic quotNegTag [`MD_STAGES];
	mdOp_t startOp;
	logic startDiv;

	always_comb begin
		if (ctrlMult) begin
			startOp = opMult;
		end else if (ctrlDiv) begin
			startOp = opDiv;
		end else begin
			startOp = opNone;
		end
		// division flags only mean something for a divide
		startDiv = (startOp == opDiv);
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `MD_STAGES; i++) begin
				opTag[i] <= opNone;
				divZeroTag[i] <= 1'b0;
				quotNegTag[i] <= 1'b0;
			end
		end else begin
			opTag[0] <= startOp;
			divZeroTag[0] <= divZero & startDiv;
			quotNegTag[0] <= quotNeg & startDiv;
			for (int i = 1; i < `MD_STAGES; i++) begin
				opTag[i] <= opTag[i-1];
				divZeroTag[i] <= divZeroTag[i-1];
				quotNegTag[i] <= quotNegTag[i-1];
			end
		end
	end

	assign lastOp = opTag[`MD_STAGES-1];
	assign lastDivZero = divZeroTag[`MD_STAGES-1];
	assign lastQuotNeg = quotNegTag[`MD_STAGES-1];

	// the requester may start only one operation per cycle
	oneStartAtATime: assert property (@(posedge clk) disable iff (!rstN)
		!(ctrlMult && ctrlDiv));

	// flags sixteen slots downstream still belong to a divide
	flagsOnDivOnly: assert property (@(posedge clk) disable iff (!rstN)
		(lastDivZero || lastQuotNeg) |-> (lastOp == opDiv));

endmodule

`default_nettype wire

// File: hw/resultStage.sv
`default_nettype none
`include "multDiv_consts.svh"

module resultStage
	import multDivPkg::*;
(
	input wire logic clk,
	input wire logic rstN,
	input wire mdOp_t lastOp,
	input wire logic lastDivZero,
	input wire logic lastQuotNeg,
	input wire boothAcc_t acc,
	input wire logic [`MD_WIDTH-1:0] quotMag,
	output logic [`MD_WIDTH-1:0] result,
	output logic exception,
	output logic resultRdy
);

	logic mulOverflow;
	logic [`MD_WIDTH-1:0] quotSigned;

	always_comb begin
		// upper product bits must all copy the sign of the low word
		mulOverflow = (acc.hi != {(`MD_WIDTH+2){acc.lo[`MD_WIDTH-1]}});
		quotSigned = lastQuotNeg ? -quotMag : quotMag;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			result <= '0;
			exception <= 1'b0;
			resultRdy <= 1'b0;
		end else begin
			resultRdy <= (lastOp != opNone);
			case (lastOp)
				opMult: begin
					result <= acc.lo;
					exception <= mulOverflow;
				end
				opDiv: begin
					if (lastDivZero) begin
						result <= '0;
						exception <= 1'b1;
					end else begin
						result <= quotSigned;
						exception <= 1'b0;
					end
				end
				// idle slot
				default: begin
					result <= '0;
					exception <= 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: multDiv.f
+incdir+hw
hw/multDivPkg.sv
hw/divSetup.sv
hw/boothStage.sv
hw/divStage.sv
hw/pipeControl.sv
hw/resultStage.sv
hw/multDiv.sv
verification/multDivChecker.sv
verification/multDivTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the multDiv testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module multDivTb -f multDiv.f -Mdir obj_dir -o multDivSim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/multDivSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
	exit 0
fi
exit 1

// File: verification/multDivChecker.sv
`default_nettype none
`include "multDiv_consts.svh"

module multDivChecker (
	input wire logic clk,
	input wire logic rstN,
	input wire logic [`MD_WIDTH-1:0] operandA,
	input wire logic [`MD_WIDTH-1:0] operandB,
	input wire logic ctrlMult,
	input wire logic ctrlDiv,
	input wire logic [`MD_WIDTH-1:0] result,
	input wire logic exception,
	input wire logic resultRdy,
	output int passCount,
	output int errorCount,
	output int pending
);
	timeunit 1ns;
	timeprecision 100ps;

	// exception bit on top of the result word
	logic [`MD_WIDTH:0] expResult [$];
	string expName [$];
	int expCycle [$];
	int cycle;

	// expected {exception, result} straight from 64-bit signed arithmetic
	function automatic logic [`MD_WIDTH:0] refCompute(input logic isDiv,
		input logic [`MD_WIDTH-1:0] a, input logic [`MD_WIDTH-1:0] b);
		longint wideA;
		longint wideB;
		longint wideRes;
		logic overflow;
		wideA = longint'($signed(a));
		wideB = longint'($signed(b));
		if (!isDiv) begin
			wideRes = wideA * wideB;
			// low word read back as signed must give the full product
			overflow = (wideRes != longint'($signed(wideRes[`MD_WIDTH-1:0])));
			return {overflow, wideRes[`MD_WIDTH-1:0]};
		end
		if (wideB == 0) begin
			return {1'b1, {`MD_WIDTH{1'b0}}};
		end
		// truncates toward zero, min / -1 wraps to 0x80000000
		wideRes = wideA / wideB;
		return {1'b0, wideRes[`MD_WIDTH-1:0]};
	endfunction

	always @(posedge clk) begin
		logic [`MD_WIDTH:0] want;
		string name;
		int latency;
		if (!rstN) begin
			expResult.delete();
			expName.delete();
			expCycle.delete();
			cycle = 0;
			passCount = 0;
			errorCount = 0;
		end else begin
			cycle++;
			if (resultRdy) begin
				if (expResult.size() == 0) begin
					$display("result 0x%08h arrived with no request outstanding", result);
					errorCount++;
				end else begin
					want = expResult.pop_front();
					name = expName.pop_front();
					// request and result are both seen one edge after they were driven
					latency = cycle - expCycle.pop_front();
					if ({exception, result} !== want) begin
						$display("ERROR %s: expected 0x%08h exc %0b, actual 0x%08h exc %0b",
							name, want[`MD_WIDTH-1:0], want[`MD_WIDTH], result, exception);
						errorCount++;
					end else if (latency != `MD_LATENCY) begin
						$display("%s: result came %0d cycles after the request, not %0d",
							name, latency, `MD_LATENCY);
						errorCount++;
					end else begin
						$display("PASS %s -> 0x%08h exc %0b", name, result, exception);
						passCount++;
					end
				end
			end else if (exception) begin
				$display("exception was high on a cycle without a result");
				errorCount++;
			end
			if (ctrlMult || ctrlDiv) begin
				expResult.push_back(refCompute(ctrlDiv, operandA, operandB));
				if (ctrlDiv) begin
					name = $sformatf("div %0d / %0d", $signed(operandA), $signed(operandB));
				end else begin
					name = $sformatf("mult %0d * %0d", $signed(operandA), $signed(operandB));
				end
				expName.push_back(name);
				expCycle.push_back(cycle);
			end
		end
		pending = expResult.size();
	end

endmodule

`default_nettype wire

// File: verification/multDivTb.sv
`default_nettype none
`include "multDiv_consts.svh"

module multDivTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int resetCycles = 5;
	localparam int numDirected = 23;
	localparam int numRandom = 200;
	// every directed request is followed by one idle cycle
	localparam int cycleLimit = resetCycles + 2 * numDirected + numRandom + `MD_LATENCY + 50;

	logic clk;
	logic rstN;
	logic [`MD_WIDTH-1:0] operandA;
	logic [`MD_WIDTH-1:0] operandB;
	logic ctrlMult;
	logic ctrlDiv;
	wire logic [`MD_WIDTH-1:0] result;
	wire logic exception;
	wire logic resultRdy;
	int passCount;
	int errorCount;
	int pending;
	int requestCount;
	int timeoutCycles;

	multDiv uut (
		.clk(clk),
		.rstN(rstN),
		.operandA(operandA),
		.operandB(operandB),
		.ctrlMult(ctrlMult),
		.ctrlDiv(ctrlDiv),
		.result(result),
		.exception(exception),
		.resultRdy(resultRdy)
	);

	multDivChecker resultCheck (
		.clk(clk),
		.rstN(rstN),
		.operandA(operandA),
		.operandB(operandB),
		.ctrlMult(ctrlMult),
		.ctrlDiv(ctrlDiv),
		.result(result),
		.exception(exception),
		.resultRdy(resultRdy),
		.passCount(passCount),
		.errorCount(errorCount),
		.pending(pending)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// one-cycle request, driven just after the edge
	task automatic issueRequest(input logic isDiv, input logic [`MD_WIDTH-1:0] a,
		input logic [`MD_WIDTH-1:0] b);
		@(posedge clk);
		#2;
		operandA = a;
		operandB = b;
		ctrlMult = !isDiv;
		ctrlDiv = isDiv;
		requestCount++;
	endtask

	task automatic idleCycle();
		@(posedge clk);
		#2;
		operandA = '0;
		operandB = '0;
		ctrlMult = 1'b0;
		ctrlDiv = 1'b0;
	endtask

	task automatic runDirected(input logic isDiv, input logic [`MD_WIDTH-1:0] a,
		input logic [`MD_WIDTH-1:0] b);
		issueRequest(isDiv, a, b);
		idleCycle();
	endtask

	task automatic runRandomBurst(input int count);
		logic [31:0] randBits;
		logic [`MD_WIDTH-1:0] a;
		logic [`MD_WIDTH-1:0] b;
		for (int i = 0; i < count; i++) begin
			randBits = $urandom;
			a = $urandom;
			// shorter divisors give quotients with more digits
			b = $urandom >> ($urandom % 32);
			issueRequest(randBits[0], a, b);
		end
		idleCycle();
	endtask

	initial begin
		timeoutCycles = 0;
		while (timeoutCycles < cycleLimit) begin
			@(posedge clk);
			timeoutCycles++;
		end
		$display("timeout after %0d cycles, %0d results never arrived", timeoutCycles, pending);
		$display("tests failed");
		$finish;
	end

	initial begin
		void'($urandom(32'hb4e));
		rstN = 1'b0;
		operandA = '0;
		operandB = '0;
		ctrlMult = 1'b0;
		ctrlDiv = 1'b0;
		requestCount = 0;
		repeat (resetCycles) @(posedge clk);
		#2;
		rstN = 1'b1;
		// a few quiet cycles straight after reset
		repeat (3) idleCycle();

		// multiplies
		runDirected(1'b0, 32'd3, 32'd4);
		runDirected(1'b0, -32'sd3, 32'd4);
		runDirected(1'b0, -32'sd3, -32'sd4);
		runDirected(1'b0, 32'd0, 32'h12345678);
		runDirected(1'b0, 32'd1, -32'sd1);
		runDirected(1'b0, -32'sd1, -32'sd1);
		runDirected(1'b0, 32'h7fffffff, 32'd2);
		runDirected(1'b0, 32'h80000000, -32'sd1);
		runDirected(1'b0, 32'h80000000, 32'd1);
		runDirected(1'b0, 32'd65536, 32'd65536);
		runDirected(1'b0, -32'sd65536, 32'd32768);

		// divides across all sign combinations
		runDirected(1'b1, 32'd100, 32'd7);
		runDirected(1'b1, -32'sd100, 32'd7);
		runDirected(1'b1, 32'd100, -32'sd7);
		runDirected(1'b1, -32'sd100, -32'sd7);
		runDirected(1'b1, 32'd3, 32'd10);
		runDirected(1'b1, -32'sd3, 32'd10);
		runDirected(1'b1, 32'h80000000, -32'sd1);
		runDirected(1'b1, 32'h80000000, 32'd1);
		runDirected(1'b1, 32'h7fffffff, 32'h7fffffff);
		runDirected(1'b1, -32'sd1, 32'h80000000);

		// divide by zero
		runDirected(1'b1, 32'd5, 32'd0);
		runDirected(1'b1, 32'h80000000, 32'd0);

		runRandomBurst(numRandom);

		while (pending != 0) begin
			@(posedge clk);
		end
		// stay idle a little longer to catch stray results
		repeat (5) idleCycle();

		$display("summary: %0d requests, %0d passed, %0d errors",
			requestCount, passCount, errorCount);
		if (errorCount == 0 && passCount == requestCount) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
